//--- hdl/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int xlen        = 32;
    localparam int tag_width   = 5;                    // 32 rob entries
    localparam int issue_width = 3;                    // also number of cdb lanes
    localparam int num_alu     = 3;
    localparam int num_mult    = 3;
    localparam int slot_count  = num_mult + num_alu;   // mult slots first, then alu
    localparam int mult_stages = 4;

    typedef enum logic {
        func_alu  = 1'b0,
        func_mult = 1'b1
    } func_unit_t;

    typedef enum logic [3:0] {
        alu_add  = 4'h0,
        alu_sub  = 4'h1,
        alu_and  = 4'h2,
        alu_or   = 4'h3,
        alu_xor  = 4'h4,
        alu_slt  = 4'h5,
        alu_sltu = 4'h6,
        alu_sll  = 4'h7,
        alu_srl  = 4'h8,
        alu_sra  = 4'h9
    } alu_op_t;

    // upper encodings unused
    typedef enum logic [3:0] {
        mult_mul    = 4'h0,
        mult_mulh   = 4'h1,
        mult_mulhsu = 4'h2,
        mult_mulhu  = 4'h3
    } mult_op_t;

    // one op field, decoded differently by each unit kind
    typedef union packed {
        alu_op_t  alu;
        mult_op_t mult;
    } op_u;

    typedef struct packed {
        logic                 valid;
        logic [tag_width-1:0] tag;
        func_unit_t           func_unit;
        op_u                  op;
        logic [xlen-1:0]      opa;
        logic [xlen-1:0]      opb;
    } issue_packet_t;

    typedef struct packed {
        logic                 valid;
        logic [tag_width-1:0] tag;
        logic [xlen-1:0]      value;
    } result_t;

    typedef struct packed {
        logic [num_alu-1:0]  alu_empty;
        logic [num_mult-1:0] mult_empty;
    } fu_empty_t;

endpackage

`default_nettype wire

//--- hdl/alu_unit.sv
`default_nettype none

module alu_unit import exec_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  logic          clear,
    input  issue_packet_t issue,
    input  logic          slot_busy,
    output result_t       result,
    output logic          empty
);

    logic            take;
    logic            hold;
    logic [4:0]      shamt;
    logic [xlen-1:0] value;

    assign take  = issue.valid && (issue.func_unit == func_alu);
    assign hold  = result.valid && slot_busy;   // slot still full, keep our result
    assign shamt = issue.opb[4:0];
    assign empty = !hold;

    always_comb begin
        case (issue.op.alu)
            alu_add: begin
                value = issue.opa + issue.opb;
            end
            alu_sub: begin
                value = issue.opa - issue.opb;
            end
            alu_and: begin
                value = issue.opa & issue.opb;
            end
            alu_or: begin
                value = issue.opa | issue.opb;
            end
            alu_xor: begin
                value = issue.opa ^ issue.opb;
            end
            alu_slt: begin
                value = {{(xlen-1){1'b0}}, $signed(issue.opa) < $signed(issue.opb)};
            end
            alu_sltu: begin
                value = {{(xlen-1){1'b0}}, issue.opa < issue.opb};
            end
            alu_sll: begin
                value = issue.opa << shamt;
            end
            alu_srl: begin
                value = issue.opa >> shamt;
            end
            alu_sra: begin
                value = $signed(issue.opa) >>> shamt;   // keeps sign bit
            end
            default: begin
                value = '0;
            end
        endcase
    end

    // result register, frozen while the buffer can't take it
    always_ff @(posedge clock) begin
        if (reset || clear) begin
            result.valid <= 1'b0;
        end else if (!hold) begin
            result.valid <= take;   // drops when nothing new arrives
            result.tag   <= issue.tag;
            result.value <= value;
        end
    end

endmodule

`default_nettype wire

//--- hdl/mult_unit.sv
`default_nettype none

module mult_unit import exec_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  logic          clear,
    input  issue_packet_t issue,
    input  logic          slot_busy,
    output result_t       result,
    output logic          empty
);

    // one pipeline stage: operands widened to 2*xlen plus running sum
    typedef struct packed {
        logic                 valid;
        logic [tag_width-1:0] tag;
        mult_op_t             op;
        logic [2*xlen-1:0]    mcand;
        logic [2*xlen-1:0]    mplier;
        logic [2*xlen-1:0]    acc;
    } stage_t;

    stage_t            stage_q [mult_stages];
    stage_t            stage_d [mult_stages];
    logic              take;
    logic              stall;
    logic              a_signed;
    logic              b_signed;
    logic [2*xlen-1:0] mcand_in;
    logic [2*xlen-1:0] mplier_in;
    logic [2*xlen-1:0] prod;

    assign take     = issue.valid && (issue.func_unit == func_mult);
    assign a_signed = (issue.op.mult == mult_mulh) || (issue.op.mult == mult_mulhsu);
    assign b_signed = (issue.op.mult == mult_mulh);
    assign stall    = stage_q[mult_stages-1].valid && slot_busy;
    assign empty    = !stall;

    // sign or zero extend, low 2*xlen bits of the product are then exact
    assign mcand_in  = {{xlen{a_signed & issue.opa[xlen-1]}}, issue.opa};
    assign mplier_in = {{xlen{b_signed & issue.opb[xlen-1]}}, issue.opb};

    // each stage adds one chunk of the multiplier
    always_comb begin
        stage_d[0].valid  = take;
        stage_d[0].tag    = issue.tag;
        stage_d[0].op     = issue.op.mult;
        stage_d[0].mcand  = mcand_in;
        stage_d[0].mplier = mplier_in;
        stage_d[0].acc    = mcand_in * mplier_in[0 +: 2*xlen/mult_stages];
        for (int k = 1; k < mult_stages; k++) begin
            stage_d[k]     = stage_q[k-1];
            stage_d[k].acc = stage_q[k-1].acc
                           + ((stage_q[k-1].mcand
                              * stage_q[k-1].mplier[k*(2*xlen/mult_stages) +: 2*xlen/mult_stages])
                              << (k*(2*xlen/mult_stages)));
        end
    end

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            for (int k = 0; k < mult_stages; k++) begin
                stage_q[k].valid <= 1'b0;
            end
        end else if (!stall) begin
            stage_q <= stage_d;   // whole pipe moves or none of it
        end
    end

    assign prod = stage_q[mult_stages-1].acc;

    always_comb begin
        result.valid = stage_q[mult_stages-1].valid;
        result.tag   = stage_q[mult_stages-1].tag;
        if (stage_q[mult_stages-1].op == mult_mul) begin
            result.value = prod[xlen-1:0];
        end else begin
            result.value = prod[2*xlen-1:xlen];   // upper word
        end
    end

endmodule

`default_nettype wire

//--- hdl/complete_buffer.sv
`default_nettype none

module complete_buffer import exec_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      clear,
    input  result_t [num_alu-1:0]     alu_result,
    input  result_t [num_mult-1:0]    mult_result,
    output logic [num_alu-1:0]        alu_slot_busy,
    output logic [num_mult-1:0]       mult_slot_busy,
    output result_t [issue_width-1:0] cdb
);

    result_t                   slots [slot_count];
    result_t                   incoming [slot_count];
    logic [slot_count-1:0]     taken;       // slot goes out on the cdb this edge
    result_t [issue_width-1:0] cdb_d;

    // unit results in slot order
    always_comb begin
        for (int i = 0; i < num_mult; i++) begin
            incoming[i] = mult_result[i];
        end
        for (int j = 0; j < num_alu; j++) begin
            incoming[num_mult + j] = alu_result[j];
        end
    end

    // lowest occupied slots first, lanes fill from 0 up
    always_comb begin
        int lane;
        lane  = 0;
        cdb_d = '0;
        taken = '0;
        for (int s = 0; s < slot_count; s++) begin
            if (slots[s].valid && (lane < issue_width)) begin
                cdb_d[lane] = slots[s];
                taken[s]    = 1'b1;
                lane        = lane + 1;
            end
        end
    end

    // busy straight from the registered slot state
    always_comb begin
        for (int i = 0; i < num_mult; i++) begin
            mult_slot_busy[i] = slots[i].valid;
        end
        for (int j = 0; j < num_alu; j++) begin
            alu_slot_busy[j] = slots[num_mult + j].valid;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            cdb <= '0;
            for (int s = 0; s < slot_count; s++) begin
                slots[s].valid <= 1'b0;
            end
        end else begin
            cdb <= cdb_d;
            for (int s = 0; s < slot_count; s++) begin
                if (!slots[s].valid && incoming[s].valid) begin
                    slots[s] <= incoming[s];   // fill only an empty slot
                end else if (taken[s]) begin
                    slots[s].valid <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/exec_stage.sv
`default_nettype none

module exec_stage import exec_pkg::*; (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            clear,
    input  issue_packet_t [issue_width-1:0] issue,
    output result_t [issue_width-1:0]       cdb,
    output fu_empty_t                       fu_empty
);

    wire result_t [num_alu-1:0]  alu_result;
    wire result_t [num_mult-1:0] mult_result;
    wire [num_alu-1:0]           alu_slot_busy;
    wire [num_mult-1:0]          mult_slot_busy;
    wire [num_alu-1:0]           alu_empty;
    wire [num_mult-1:0]          mult_empty;

    // way i feeds alu i, the unit filters on func_unit
    for (genvar i = 0; i < num_alu; i++) begin : g_alu
        alu_unit alu_unit_i (
            .clock     (clock),
            .reset     (reset),
            .clear     (clear),
            .issue     (issue[i]),
            .slot_busy (alu_slot_busy[i]),
            .result    (alu_result[i]),
            .empty     (alu_empty[i])
        );
    end

    // same way also feeds mult i
    for (genvar i = 0; i < num_mult; i++) begin : g_mult
        mult_unit mult_unit_i (
            .clock     (clock),
            .reset     (reset),
            .clear     (clear),
            .issue     (issue[i]),
            .slot_busy (mult_slot_busy[i]),
            .result    (mult_result[i]),
            .empty     (mult_empty[i])
        );
    end

    complete_buffer complete_buffer_i (
        .clock          (clock),
        .reset          (reset),
        .clear          (clear),
        .alu_result     (alu_result),
        .mult_result    (mult_result),
        .alu_slot_busy  (alu_slot_busy),
        .mult_slot_busy (mult_slot_busy),
        .cdb            (cdb)
    );

    assign fu_empty = '{alu_empty: alu_empty, mult_empty: mult_empty};

endmodule

`default_nettype wire

//--- verif/clock_gen.sv
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;   // period 4
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/exec_stage_assertions.sv
`default_nettype none

module exec_stage_assertions import exec_pkg::*; (
    input wire logic                            clock,
    input wire logic                            reset,
    input wire logic                            clear,
    input wire issue_packet_t [issue_width-1:0] issue,
    input wire result_t [issue_width-1:0]       cdb,
    input wire fu_empty_t                       fu_empty
);

    logic any_issue;
    logic alu_only;
    logic any_cdb;
    int   fail_count;   // read by the testbench

    assign any_issue = issue[0].valid || issue[1].valid || issue[2].valid;
    assign any_cdb   = cdb[0].valid || cdb[1].valid || cdb[2].valid;

    always_comb begin
        alu_only = any_issue;
        for (int i = 0; i < issue_width; i++) begin
            if (issue[i].valid && issue[i].func_unit != func_alu) begin
                alu_only = 1'b0;
            end
        end
    end

    for (genvar i = 0; i < issue_width; i++) begin : g_way
        // no issue into a stalled unit
        assert property (@(posedge clock) disable iff (reset)
            (issue[i].valid && issue[i].func_unit == func_alu) |-> fu_empty.alu_empty[i])
            else begin
                $error("issue to stalled alu");
                fail_count++;
            end
        assert property (@(posedge clock) disable iff (reset)
            (issue[i].valid && issue[i].func_unit == func_mult) |-> fu_empty.mult_empty[i])
            else begin
                $error("issue to stalled multiplier");
                fail_count++;
            end
    end

    // long quiet spell drains everything, so the alu latency is exact
    assert property (@(posedge clock) disable iff (reset || clear)
        (!any_issue && !any_cdb)[*8] ##1 alu_only
            |-> ##1 !cdb[0].valid ##1 !cdb[0].valid ##1 cdb[0].valid)
        else begin
            $error("alu burst missed the three cycle cdb slot");
            fail_count++;
        end

    assert property (@(posedge clock) reset |=> !any_cdb)
        else begin
            $error("cdb valid right after reset");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- verif/exec_stage_tb.sv
`default_nettype none

module exec_stage_tb import exec_pkg::*; ();

    logic                            clock;
    logic                            reset;
    logic                            clear;
    issue_packet_t [issue_width-1:0] issue_drv;   // what the stimulus wants
    issue_packet_t [issue_width-1:0] issue;       // gated by fu_empty
    result_t [issue_width-1:0]       cdb;
    fu_empty_t                       fu_empty;

    logic [31:0]     pending;                     // one bit per tag
    logic [xlen-1:0] exp_val [32];
    int              pending_count;
    logic [4:0]      tag_ctr;
    int              pause;

    clock_gen clock_gen_i (.clock(clock), .reset(reset));

    exec_stage exec_stage_i (
        .clock    (clock),
        .reset    (reset),
        .clear    (clear),
        .issue    (issue),
        .cdb      (cdb),
        .fu_empty (fu_empty)
    );

    bind exec_stage exec_stage_assertions exec_stage_assertions_i (
        .clock(clock), .reset(reset), .clear(clear),
        .issue(issue), .cdb(cdb), .fu_empty(fu_empty)
    );

    // a way only raises valid while its target unit is empty
    always_comb begin
        issue = issue_drv;
        for (int i = 0; i < issue_width; i++) begin
            if (issue_drv[i].func_unit == func_alu) begin
                issue[i].valid = issue_drv[i].valid && fu_empty.alu_empty[i];
            end else begin
                issue[i].valid = issue_drv[i].valid && fu_empty.mult_empty[i];
            end
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_result(input result_t got, input result_t exp, input int lane);
        if (got !== exp) begin
            stop_run($sformatf("FAIL cdb[%0d] got %h expected %h", lane, got, exp));
        end
    endtask

    task automatic check_empty(input fu_empty_t got, input fu_empty_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL fu_empty got %h expected %h", got, exp));
        end
    endtask

    task automatic poll_assertions();
        if (exec_stage_i.exec_stage_assertions_i.fail_count != 0) begin
            stop_run("a concurrent assertion on exec_stage failed");
        end
    endtask

    function automatic logic [xlen-1:0] alu_ref(input alu_op_t op, input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
        logic signed [xlen-1:0] sa;
        logic signed [xlen-1:0] sb;
        sa = a;
        sb = b;
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_slt:  return (sa < sb) ? 1 : 0;
            alu_sltu: return (a < b) ? 1 : 0;
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return sa >>> b[4:0];
            default:  return '0;
        endcase
    endfunction

    function automatic logic [xlen-1:0] mult_ref(input mult_op_t op, input logic [xlen-1:0] a,
                                                 input logic [xlen-1:0] b);
        logic [2*xlen-1:0] x;
        logic [2*xlen-1:0] y;
        logic [2*xlen-1:0] p;
        x = {{xlen{(op == mult_mulh || op == mult_mulhsu) && a[xlen-1]}}, a};
        y = {{xlen{(op == mult_mulh) && b[xlen-1]}}, b};
        p = x * y;   // mod 2^64 is enough for both words
        return (op == mult_mul) ? p[xlen-1:0] : p[2*xlen-1:xlen];
    endfunction

    function automatic logic [xlen-1:0] rand_operand();
        case ($urandom % 6)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hffff_ffff;
            3:       return 32'h8000_0000;
            4:       return 32'h7fff_ffff;
            default: return $urandom;
        endcase
    endfunction

    // runs right after a rising edge, sees pre-edge values
    task automatic observe();
        logic    gap;
        result_t exp;
        gap = 1'b0;
        poll_assertions();
        if (reset) return;
        for (int l = 0; l < issue_width; l++) begin
            if (!cdb[l].valid) begin
                gap = 1'b1;
            end else if (gap) begin
                stop_run($sformatf("cdb lane %0d is valid above an empty lane", l));
            end else if (!pending[cdb[l].tag]) begin
                stop_run($sformatf("tag %h came out on the cdb but was not expected", cdb[l].tag));
            end else begin
                exp = '{valid: 1'b1, tag: cdb[l].tag, value: exp_val[cdb[l].tag]};
                check_result(cdb[l], exp, l);
                pending[cdb[l].tag] = 1'b0;
                pending_count--;
            end
        end
        if (pending_count == 0) begin
            check_empty(fu_empty, '1);   // nothing in flight, nothing stalled
        end
        if (clear) begin
            pending       = '0;
            pending_count = 0;
        end else begin
            for (int i = 0; i < issue_width; i++) begin
                if (issue[i].valid) begin
                    pending[issue[i].tag] = 1'b1;
                    pending_count++;
                    if (issue[i].func_unit == func_alu) begin
                        exp_val[issue[i].tag] = alu_ref(issue[i].op.alu, issue[i].opa,
                                                        issue[i].opb);
                    end else begin
                        exp_val[issue[i].tag] = mult_ref(issue[i].op.mult, issue[i].opa,
                                                         issue[i].opb);
                    end
                end
            end
        end
    endtask

    task automatic drive();
        issue_packet_t p;
        clear <= ($urandom % 400) == 0;
        if (pause == 0 && ($urandom % 10) == 0) begin
            pause = 1 + $urandom % 20;
        end
        for (int i = 0; i < issue_width; i++) begin
            p           = '0;
            p.func_unit = ($urandom % 2) ? func_mult : func_alu;
            if (p.func_unit == func_alu) begin
                p.op.alu = alu_op_t'($urandom % 10);
            end else begin
                p.op.mult = mult_op_t'($urandom % 4);
            end
            p.opa   = rand_operand();
            p.opb   = rand_operand();
            p.tag   = tag_ctr;
            p.valid = (pause == 0) && (($urandom % 4) != 0) && !pending[tag_ctr];
            tag_ctr = tag_ctr + 1;
            issue_drv[i] <= p;
        end
        if (pause > 0) pause--;
    endtask

    initial begin
        int wait_cycles;
        issue_drv     = '0;
        clear         = 1'b0;
        pending       = '0;
        pending_count = 0;
        tag_ctr       = '0;
        pause         = 0;
        void'($urandom(32'h235bc88c));
        wait_cycles = 0;
        while (reset !== 1'b0) begin
            @(posedge clock);
            wait_cycles++;
            if (wait_cycles > 50) stop_run("reset never went low");
        end
        for (int c = 0; c < 2000; c++) begin
            @(posedge clock);
            observe();
            drive();
        end
        @(posedge clock);
        observe();
        issue_drv <= '0;
        clear     <= 1'b0;
        wait_cycles = 0;
        while (pending_count != 0 && wait_cycles < 300) begin
            @(posedge clock);
            observe();
            wait_cycles++;
        end
        @(negedge clock);
        poll_assertions();
        if (pending_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("drain timed out with %0d results still outstanding", pending_count);
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
hdl/exec_pkg.sv
hdl/alu_unit.sv
hdl/mult_unit.sv
hdl/complete_buffer.sv
hdl/exec_stage.sv
verif/clock_gen.sv
verif/exec_stage_assertions.sv
verif/exec_stage_tb.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  - files:
      - hdl/exec_pkg.sv
      - hdl/alu_unit.sv
      - hdl/mult_unit.sv
      - hdl/complete_buffer.sv
      - hdl/exec_stage.sv
  - target: test
    files:
      - verif/clock_gen.sv
      - verif/exec_stage_assertions.sv
      - verif/exec_stage_tb.sv
